// ==== Bender.yml ====
package:
  name: zx_ula

sources:
  - design/zx_timing_pkg.sv
  - design/zx_bus_pkg.sv
  - design/raster_timer.sv
  - design/screen_fetch.sv
  - design/io_ports.sv
  - design/mem_map.sv
  - design/zx_ula.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_zx_ula.sv

// ==== compile.f ====
design/zx_timing_pkg.sv
design/zx_bus_pkg.sv
design/raster_timer.sv
design/screen_fetch.sv
design/io_ports.sv
design/mem_map.sv
design/zx_ula.sv
sim/tb_clock.sv
sim/tb_zx_ula.sv

// ==== design/io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_ports (
	input  logic                 clk28,
	input  logic                 rst_n,
	input  zx_bus_pkg::cpu_bus_t bus,
	input  logic [7:0]           xd_in,
	input  logic [4:0]           kd,
	input  logic                 tape_in,
	output zx_bus_pkg::border_t  border,
	output logic                 beeper,
	output logic                 tape_out,
	output zx_bus_pkg::paging_t  paging,
	output logic [7:0]           rd_data,
	output logic                 rd_en
);

logic io_cycle;
logic fe_cs;
logic p7ffd_cs;

assign io_cycle = !bus.n_iorq && bus.n_m1; // not an interrupt ack
assign fe_cs = io_cycle && (bus.a & zx_bus_pkg::PORT_FE_MASK) == 16'h0000;
assign p7ffd_cs = io_cycle && (bus.a & zx_bus_pkg::PORT_7FFD_MASK) == 16'h0000;

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		border <= '0;
		beeper <= 1'b0;
		tape_out <= 1'b0;
	end
	else if (fe_cs && !bus.n_wr) begin
		beeper <= xd_in[4];
		tape_out <= xd_in[3];
		border <= xd_in[2:0];
	end
end

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		paging <= '0;
	end
	else if (p7ffd_cs && !bus.n_wr && !paging.lock) begin
		paging.rambank <= xd_in[2:0];
		paging.vbank <= xd_in[3];
		paging.rombank <= xd_in[4];
		paging.lock <= xd_in[5]; // sticky until reset
	end
end

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n)
		rd_en <= 1'b0;
	else
		rd_en <= fe_cs && !bus.n_rd;
end

always_ff @(posedge clk28) begin
	if (fe_cs && !bus.n_rd)
		rd_data <= {1'b1, tape_in, 1'b1, kd};
end

endmodule

`default_nettype wire

// ==== design/mem_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_map (
	input  logic                 clk28,
	input  logic                 rst_n,
	input  zx_bus_pkg::cpu_bus_t bus,
	input  zx_bus_pkg::paging_t  paging,
	input  logic                 screen_read,
	input  logic [14:0]          screen_addr,
	output logic [18:0]          va,
	output logic [2:0]           ra,
	output logic                 n_romcs,
	output logic                 n_vrd,
	output logic                 n_vwr,
	output logic                 cpu_ram_rd
);

logic mem_cycle;
logic rom_area;
logic [2:0] page;
logic n_romcs_q;
logic n_ramcs_q;
logic n_vwr_q;
logic [5:0] ram_a; // 8K block of the 512K RAM

assign mem_cycle = !bus.n_mreq && bus.n_rfsh;
assign rom_area = bus.a[15:14] == 2'b00;

always_comb begin
	case (bus.a[15:14])
		2'b01: page = 3'd5;
		2'b10: page = 3'd2;
		2'b11: page = paging.rambank;
		default: page = 3'd0;
	endcase
end

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		n_romcs_q <= 1'b1;
		n_ramcs_q <= 1'b1;
		n_vwr_q <= 1'b1;
		ram_a <= '0;
	end
	else begin
		n_romcs_q <= !(mem_cycle && rom_area);
		n_ramcs_q <= !(mem_cycle && !rom_area);
		n_vwr_q <= !(mem_cycle && !rom_area && !bus.n_wr);
		ram_a <= {2'b11, page, bus.a[13]};
	end
end

assign n_romcs = n_romcs_q | bus.n_mreq;
assign n_vrd = (n_ramcs_q | bus.n_rd) & !screen_read;
assign n_vwr = n_vwr_q | bus.n_wr | screen_read; // fetcher owns the bus
assign cpu_ram_rd = !n_ramcs_q && !bus.n_rd;

assign va = screen_read ? {3'b111, paging.vbank, screen_addr} : {ram_a, bus.a[12:0]};
assign ra = {2'b00, paging.rombank};

endmodule

`default_nettype wire

// ==== design/raster_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timer (
	input  logic                   clk28,
	input  logic                   rst_n,
	output zx_timing_pkg::raster_t raster,
	output logic                   n_int,
	output logic                   blink,
	output logic                   clkcpu
);

zx_timing_pkg::hcount_t hc;
zx_timing_pkg::vcount_t vc;
logic [1:0] sub;
logic ck7;
logic line_end;
logic hsync_d;
logic vsync_d;
logic int_d;
logic hsync_q;
logic vsync_q;
logic int_prev;
logic [zx_timing_pkg::BLINK_BITS-1:0] blink_cnt;

assign ck7 = sub == 2'd3;
assign line_end = ck7 && hc == zx_timing_pkg::H_TOTAL - 1;

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		sub <= '0;
		hc <= '0;
		vc <= '0;
	end
	else begin
		sub <= sub + 2'd1;
		if (line_end) begin
			hc <= '0;
			if (vc == zx_timing_pkg::V_TOTAL - 1)
				vc <= '0;
			else
				vc <= vc + 9'd1;
		end
		else if (ck7) begin
			hc <= hc + 9'd1;
		end
	end
end

assign hsync_d = hc >= zx_timing_pkg::H_SYNC_START && hc < zx_timing_pkg::H_SYNC_END;
assign vsync_d = vc >= zx_timing_pkg::V_SYNC_START && vc < zx_timing_pkg::V_SYNC_END;
assign int_d = vc == zx_timing_pkg::INT_LINE &&
	hc >= zx_timing_pkg::INT_H_FROM && hc < zx_timing_pkg::INT_H_TO;

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		hsync_q <= 1'b0;
		vsync_q <= 1'b0;
		n_int <= 1'b1;
		clkcpu <= 1'b0;
	end
	else begin
		hsync_q <= hsync_d;
		vsync_q <= vsync_d;
		n_int <= !int_d;
		clkcpu <= hc[0]; // 3.5 MHz
	end
end

// flash counter steps at the end of each interrupt
always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		int_prev <= 1'b1;
		blink_cnt <= '0;
	end
	else begin
		int_prev <= n_int;
		if (n_int && !int_prev)
			blink_cnt <= blink_cnt + 1'b1;
	end
end

assign blink = blink_cnt[zx_timing_pkg::BLINK_BITS-1];

always_comb begin
	raster.hc = hc;
	raster.vc = vc;
	raster.sub = sub;
	raster.ck7 = ck7;
	raster.ck14 = sub[0];
	raster.blank = vsync_d ||
		(hc >= zx_timing_pkg::H_BLANK_START && hc < zx_timing_pkg::H_BLANK_END);
	raster.hsync = hsync_q;
	raster.vsync = vsync_q;
	raster.screen_load = vc < zx_timing_pkg::V_AREA && (hc < zx_timing_pkg::H_AREA || line_end);
	raster.screen_show = vc < zx_timing_pkg::V_AREA &&
		hc >= zx_timing_pkg::SCREEN_DELAY - 1 &&
		hc < zx_timing_pkg::H_AREA + zx_timing_pkg::SCREEN_DELAY - 1;
	raster.line_end = line_end;
end

endmodule

`default_nettype wire

// ==== design/screen_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module screen_fetch (
	input  logic                   clk28,
	input  logic                   rst_n,
	input  zx_timing_pkg::raster_t raster,
	input  logic                   blink,
	input  zx_bus_pkg::border_t    border,
	input  logic                   cpu_idle,
	input  logic [7:0]             vd_in,
	output logic                   screen_read,
	output logic [14:0]            screen_addr,
	output logic [1:0]             r,
	output logic [1:0]             g,
	output logic [1:0]             b,
	output logic                   csync,
	output logic                   hsync,
	output logic                   vsync
);

logic clk7;
logic cell_end;
logic [14:0] bitmap_addr;
logic [14:0] attr_addr;
logic [7:0] bitmap;
logic [7:0] attr;
logic [7:0] bitmap_next;
logic [7:0] attr_next;
logic ink_sel;
logic [2:0] colour;

assign clk7 = raster.sub[1]; // attr in first half, bitmap in second
assign cell_end = {raster.hc[2:0], raster.sub} == zx_timing_pkg::FETCH_PHASE;

// third, pixel line and char row are interleaved in the bitmap
assign bitmap_addr = {2'b10, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};
assign attr_addr = {5'b10110, raster.vc[7:3], raster.hc[7:3]};
assign screen_addr = clk7 ? bitmap_addr : attr_addr;

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		screen_read <= 1'b0;
		attr_next <= '0;
		bitmap_next <= '0;
	end
	else if (raster.ck14) begin
		screen_read <= raster.screen_load && cpu_idle;
		if (screen_read && !clk7)
			attr_next <= vd_in;
		if (screen_read && clk7)
			bitmap_next <= vd_in;
	end
end

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		bitmap <= '0;
		attr <= '0;
	end
	else if (cell_end) begin
		if (raster.screen_show) begin
			bitmap <= bitmap_next;
			attr <= attr_next;
		end
		else begin
			bitmap <= '0;
			attr <= {2'b00, border, 3'b000}; // border as paper, no bright
		end
	end
	else if (raster.ck7) begin
		bitmap <= {bitmap[6:0], 1'b0};
	end
end

assign ink_sel = bitmap[7] ^ (attr[7] & blink);
assign colour = ink_sel ? attr[2:0] : attr[5:3];

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		{g, r, b} <= '0;
		csync <= 1'b1;
		hsync <= 1'b0;
		vsync <= 1'b0;
	end
	else if (raster.ck7) begin
		if (raster.blank) begin
			{g, r, b} <= '0;
		end
		else begin
			{g[1], r[1], b[1]} <= colour;
			{g[0], r[0], b[0]} <= {3{(|colour) & attr[6]}}; // bright, black stays black
		end
		csync <= ~(raster.hsync ^ raster.vsync);
		hsync <= raster.hsync;
		vsync <= raster.vsync;
	end
end

endmodule

`default_nettype wire

// ==== design/zx_bus_pkg.sv ====
`default_nettype none

package zx_bus_pkg;

	// a port is selected when all masked address bits are low
	localparam logic [15:0] PORT_FE_MASK   = 16'h0001;
	localparam logic [15:0] PORT_7FFD_MASK = 16'h8002;

	typedef logic [2:0] border_t; // {g, r, b}

	typedef struct packed {
		logic [15:0] a;
		logic        n_rd;
		logic        n_wr;
		logic        n_mreq;
		logic        n_iorq;
		logic        n_m1;
		logic        n_rfsh;
	} cpu_bus_t;

	typedef struct packed {
		logic [2:0] rambank; // page at c000
		logic       vbank;   // screen in page 7 instead of 5
		logic       rombank;
		logic       lock;
	} paging_t;

endpackage

`default_nettype wire

// ==== design/zx_timing_pkg.sv ====
`default_nettype none

package zx_timing_pkg;

	localparam int H_AREA       = 256;
	localparam int V_AREA       = 192;
	localparam int SCREEN_DELAY = 8;

	// pentagon line, in pixels
	localparam int H_RBORDER = 64;
	localparam int H_BLANK1  = 8;
	localparam int H_SYNC    = 33;
	localparam int H_BLANK2  = 31;
	localparam int H_LBORDER = 56;
	localparam int H_TOTAL   = H_AREA + H_RBORDER + H_BLANK1 + H_SYNC + H_BLANK2 + H_LBORDER;

	localparam int H_BLANK_START = H_AREA + H_RBORDER;
	localparam int H_SYNC_START  = H_BLANK_START + H_BLANK1;
	localparam int H_SYNC_END    = H_SYNC_START + H_SYNC;
	localparam int H_BLANK_END   = H_SYNC_END + H_BLANK2;

	// pentagon frame, in lines
	localparam int V_BBORDER    = 56;
	localparam int V_SYNC       = 8;
	localparam int V_TBORDER    = 64;
	localparam int V_TOTAL      = V_AREA + V_BBORDER + V_SYNC + V_TBORDER;
	localparam int V_SYNC_START = V_AREA + V_BBORDER;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	localparam int INT_LINE   = 239;
	localparam int INT_H_FROM = 318;
	localparam int INT_H_TO   = 384;

	localparam int BLINK_BITS = 5;
	localparam logic [4:0] FETCH_PHASE = 5'd30; // {hc[2:0], sub} of cell load

	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	typedef struct packed {
		hcount_t    hc;
		vcount_t    vc;
		logic [1:0] sub;
		logic       ck7;         // last tick of the pixel
		logic       ck14;        // odd tick
		logic       blank;
		logic       hsync;
		logic       vsync;
		logic       screen_load;
		logic       screen_show;
		logic       line_end;
	} raster_t;

endpackage

`default_nettype wire

// ==== design/zx_ula.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_ula (
	input  logic                 clk28,
	input  logic                 rst_n,
	input  zx_bus_pkg::cpu_bus_t bus,
	inout  wire  [7:0]           xd,
	output logic [18:0]          va,
	inout  wire  [7:0]           vd,
	output logic [2:0]           ra,
	output logic                 n_romcs,
	output logic                 n_vrd,
	output logic                 n_vwr,
	output logic                 n_int,
	output logic                 clkcpu,
	input  logic [4:0]           kd,
	input  logic                 tape_in,
	output logic [1:0]           r,
	output logic [1:0]           g,
	output logic [1:0]           b,
	output logic                 csync,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 beeper,
	output logic                 tape_out
);

zx_timing_pkg::raster_t raster;
zx_bus_pkg::border_t border;
zx_bus_pkg::paging_t paging;
logic blink;
logic cpu_idle;
logic screen_read;
logic [14:0] screen_addr;
logic [7:0] rd_data;
logic rd_en;
logic cpu_ram_rd;

// video bus is free when the cpu has no memory cycle or is refreshing
assign cpu_idle = bus.n_mreq | !bus.n_rfsh;

raster_timer u_raster (
	.clk28(clk28), .rst_n(rst_n), .raster(raster),
	.n_int(n_int), .blink(blink), .clkcpu(clkcpu)
);

screen_fetch u_fetch (
	.clk28(clk28), .rst_n(rst_n), .raster(raster), .blink(blink),
	.border(border), .cpu_idle(cpu_idle), .vd_in(vd),
	.screen_read(screen_read), .screen_addr(screen_addr),
	.r(r), .g(g), .b(b), .csync(csync), .hsync(hsync), .vsync(vsync)
);

io_ports u_ports (
	.clk28(clk28), .rst_n(rst_n), .bus(bus), .xd_in(xd), .kd(kd), .tape_in(tape_in),
	.border(border), .beeper(beeper), .tape_out(tape_out), .paging(paging),
	.rd_data(rd_data), .rd_en(rd_en)
);

mem_map u_mem (
	.clk28(clk28), .rst_n(rst_n), .bus(bus), .paging(paging),
	.screen_read(screen_read), .screen_addr(screen_addr),
	.va(va), .ra(ra), .n_romcs(n_romcs), .n_vrd(n_vrd), .n_vwr(n_vwr),
	.cpu_ram_rd(cpu_ram_rd)
);

assign xd = rd_en ? rd_data : cpu_ram_rd ? vd : 8'hzz;
assign vd = !n_vwr ? xd : 8'hzz; // cpu data to ram on writes only

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk28,
	output logic rst_n
);

localparam int HALF_PERIOD = 10; // 20 ns period
localparam int RESET_CYCLES = 8;

initial begin
	clk28 = 1'b0;
	forever #HALF_PERIOD clk28 = ~clk28;
end

initial begin
	rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk28);
	@(negedge clk28);
	rst_n = 1'b1; // released away from the active edge
end

endmodule

`default_nettype wire

// ==== sim/tb_zx_ula.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zx_ula;

localparam int H_PIXELS = 448;
localparam int LINE_TICKS = H_PIXELS * 4;
localparam int FRAME_TICKS = LINE_TICKS * 320;
localparam int INT_LOW_TICKS = (384 - 318) * 4;
localparam int CPU_CLK_TICKS = 8;
localparam int DISPLAY_W = 256;
localparam int DISPLAY_H = 192;
localparam int PIXEL_DELAY = 8;
localparam int H_BLANK_FROM = 320;
localparam int H_BLANK_TO = 392;
localparam int H_SYNC_FROM = 328;
localparam int H_SYNC_TO = 361;
localparam int V_SYNC_FROM = 248;
localparam int V_SYNC_TO = 256;
localparam int DRIVE_DELAY = 2;
localparam int N_OPS = 80;
localparam int OP_TICKS = 8;
localparam int WATCHDOG_TICKS = 3 * FRAME_TICKS + N_OPS * OP_TICKS + 4 * LINE_TICKS;

logic clk28;
logic rst_n;
zx_bus_pkg::cpu_bus_t bus;
wire [7:0] xd;
wire [7:0] vd;
logic [7:0] xd_drv;
logic xd_oe;
logic [18:0] va;
logic [2:0] ra;
logic n_romcs, n_vrd, n_vwr, n_int, clkcpu;
logic [4:0] kd;
logic tape_in;
logic [1:0] r, g, b;
logic csync, hsync, vsync, beeper, tape_out;

logic [7:0] vram [0:524287];
integer seed;
int errors;
int checks;
int cyc;

// port state as the cpu should see it
logic [2:0] border_m;
logic beeper_m, tape_out_m;
logic [2:0] rambank_m;
logic vbank_m, rombank_m, lock_m;

logic hsync_prev, vsync_prev, int_prev, cpu_prev;
int hfalls, vfalls, int_falls, cpu_rises;
int last_hfall, last_vfall, last_int_fall, last_cpu_rise;
int int_dist;
int screen_px, border_px;

tb_clock u_clock (.clk28(clk28), .rst_n(rst_n));

zx_ula UUT (
	.clk28(clk28), .rst_n(rst_n), .bus(bus), .xd(xd), .va(va), .vd(vd), .ra(ra),
	.n_romcs(n_romcs), .n_vrd(n_vrd), .n_vwr(n_vwr), .n_int(n_int), .clkcpu(clkcpu),
	.kd(kd), .tape_in(tape_in), .r(r), .g(g), .b(b),
	.csync(csync), .hsync(hsync), .vsync(vsync), .beeper(beeper), .tape_out(tape_out)
);

assign xd = xd_oe ? xd_drv : 8'hzz;
assign vd = !n_vrd ? vram[va] : 8'hzz; // ram answers reads only

always @(posedge clk28) begin
	if (!n_vwr)
		vram[va] = vd;
end

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("CHECK FAILED: %s = %h, expected %h at cycle %0d", name, actual, expected, cyc);
	end
endtask

task automatic report_problem(input string what);
	errors++;
	$display("ERROR: %s", what);
endtask

task automatic print_summary;
	$display("%0d checks, %0d errors", checks, errors);
endtask

task automatic bus_idle;
	bus.a = 16'h0000;
	bus.n_rd = 1'b1;
	bus.n_wr = 1'b1;
	bus.n_mreq = 1'b1;
	bus.n_iorq = 1'b1;
	bus.n_m1 = 1'b1;
	bus.n_rfsh = 1'b1;
	xd_oe = 1'b0;
endtask

function automatic logic [5:0] pixel_value(input logic [2:0] colour, input logic bright);
	logic lo;
	lo = bright && colour != 3'b000;
	return {colour[2], lo, colour[1], lo, colour[0], lo}; // g, r, b
endfunction

function automatic int attr_address(input int line, input int col);
	int page;
	page = vbank_m ? 7 : 5;
	return 32'h60000 + page * 16384 + 32'h1800 + (line / 8) * 32 + col;
endfunction

// 16K cpu window to its place in the 512K ram
function automatic logic [18:0] ram_address(input logic [15:0] addr);
	logic [2:0] page;
	case (addr[15:14])
		2'b01: page = 3'd5;
		2'b10: page = 3'd2;
		2'b11: page = rambank_m;
		default: page = 3'd0;
	endcase
	return {2'b11, page, addr[13:0]};
endfunction

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	@(posedge clk28);
	#DRIVE_DELAY;
	bus.a = addr;
	bus.n_iorq = 1'b0;
	bus.n_wr = 1'b0;
	xd_drv = data;
	xd_oe = 1'b1;
	repeat (2) @(posedge clk28);
	#DRIVE_DELAY;
	bus_idle();
	if (!addr[0]) begin
		border_m = data[2:0];
		tape_out_m = data[3];
		beeper_m = data[4];
	end
	if (!addr[1] && !addr[15] && !lock_m) begin // 7ffd, frozen once locked
		rambank_m = data[2:0];
		vbank_m = data[3];
		rombank_m = data[4];
		lock_m = data[5];
	end
	@(negedge clk28);
	check_value("beeper", beeper, beeper_m);
	check_value("tape_out", tape_out, tape_out_m);
endtask

task automatic fe_read(input logic [15:0] addr);
	logic [31:0] rnd;
	logic [7:0] expected;
	rnd = $random(seed);
	@(posedge clk28);
	#DRIVE_DELAY;
	bus.a = addr & 16'hfffe;
	bus.n_iorq = 1'b0;
	bus.n_rd = 1'b0;
	kd = rnd[4:0];
	tape_in = rnd[8];
	expected = {1'b1, rnd[8], 1'b1, rnd[4:0]};
	repeat (2) @(posedge clk28);
	@(negedge clk28);
	check_value("xd (port fe)", xd, expected);
	@(posedge clk28);
	#DRIVE_DELAY;
	bus_idle();
endtask

task automatic mem_read(input logic [15:0] addr);
	logic [18:0] expected_va;
	expected_va = ram_address(addr);
	@(posedge clk28);
	#DRIVE_DELAY;
	bus.a = addr;
	bus.n_mreq = 1'b0;
	bus.n_rd = 1'b0;
	repeat (3) @(posedge clk28);
	@(negedge clk28);
	check_value("n_romcs", n_romcs, addr[15:14] != 2'b00);
	check_value("ra", ra, {2'b00, rombank_m});
	if (addr[15:14] != 2'b00) begin
		check_value("va", va, expected_va);
		check_value("xd (ram read)", xd, vram[expected_va]);
	end
	@(posedge clk28);
	#DRIVE_DELAY;
	bus_idle();
endtask

task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
	logic [18:0] expected_va;
	expected_va = ram_address(addr);
	@(posedge clk28);
	#DRIVE_DELAY;
	bus.a = addr;
	bus.n_mreq = 1'b0;
	bus.n_wr = 1'b0;
	xd_drv = data;
	xd_oe = 1'b1;
	repeat (3) @(posedge clk28);
	@(negedge clk28);
	check_value("n_vwr", n_vwr, addr[15:14] == 2'b00); // rom is never written
	check_value("n_romcs", n_romcs, addr[15:14] != 2'b00);
	if (addr[15:14] != 2'b00) begin
		check_value("va", va, expected_va);
		check_value("vd (ram write)", vd, data);
	end
	@(posedge clk28);
	#DRIVE_DELAY;
	bus_idle();
endtask

task automatic watch_edges;
	if (hsync_prev && !hsync) begin
		if (hfalls > 0)
			check_value("hsync period", cyc - last_hfall, LINE_TICKS);
		hfalls++;
		last_hfall = cyc;
	end
	if (vsync_prev && !vsync) begin
		if (vfalls > 0)
			check_value("vsync period", cyc - last_vfall, FRAME_TICKS);
		vfalls++;
		last_vfall = cyc;
	end
	if (int_prev && !n_int) begin
		if (int_falls > 0)
			check_value("n_int period", cyc - last_int_fall, FRAME_TICKS);
		if (vfalls > 0 && int_dist < 0)
			int_dist = cyc - last_vfall;
		else if (vfalls > 0)
			check_value("n_int after vsync", cyc - last_vfall, int_dist);
		int_falls++;
		last_int_fall = cyc;
	end
	if (!int_prev && n_int && int_falls > 0)
		check_value("n_int low time", cyc - last_int_fall, INT_LOW_TICKS);
	if (!cpu_prev && clkcpu) begin
		if (cpu_rises > 0)
			check_value("clkcpu period", cyc - last_cpu_rise, CPU_CLK_TICKS);
		cpu_rises++;
		last_cpu_rise = cyc;
	end
	hsync_prev = hsync;
	vsync_prev = vsync;
	int_prev = n_int;
	cpu_prev = clkcpu;
endtask

task automatic check_pixel;
	int h;
	int v;
	int ph;
	int pv;
	logic blank;
	logic hs;
	logic vs;
	logic [7:0] attr;
	logic [5:0] actual;
	logic [5:0] ink;
	logic [5:0] paper;
	h = (cyc / 4) % H_PIXELS;
	v = (cyc / LINE_TICKS) % 320;
	ph = h == 0 ? H_PIXELS - 1 : h - 1; // output shows the previous pixel slot
	pv = h != 0 ? v : v == 0 ? 319 : v - 1;
	blank = (pv >= V_SYNC_FROM && pv < V_SYNC_TO) || (ph >= H_BLANK_FROM && ph < H_BLANK_TO);
	hs = ph >= H_SYNC_FROM && ph < H_SYNC_TO;
	vs = pv >= V_SYNC_FROM && pv < V_SYNC_TO;
	check_value("csync", csync, !(hs ^ vs)); // low while exactly one sync is active
	actual = {g, r, b};
	if (blank) begin
		check_value("rgb (blank)", actual, 32'h0);
	end
	else if (v < DISPLAY_H && h >= PIXEL_DELAY && h < DISPLAY_W + PIXEL_DELAY) begin
		attr = vram[attr_address(v, (h - PIXEL_DELAY) / 8)];
		ink = pixel_value(attr[2:0], attr[6]);
		paper = pixel_value(attr[5:3], attr[6]);
		check_value("rgb (screen)", actual, actual == ink ? ink : paper);
		screen_px++;
	end
	else begin
		check_value("rgb (border)", actual, pixel_value(border_m, 1'b0));
		border_px++;
	end
endtask

always @(posedge clk28 or negedge rst_n) begin
	if (!rst_n)
		cyc <= 0;
	else
		cyc <= cyc + 1;
end

// everything sampled mid cycle
always @(negedge clk28) begin
	if (rst_n) begin
		watch_edges();
		if (cyc >= FRAME_TICKS && cyc % 4 == 2) // frame 0 has cpu traffic
			check_pixel();
	end
end

initial begin
	int i;
	int kind;
	logic [31:0] rnd;
	seed = 32'h4a0254ac;
	errors = 0;
	checks = 0;
	{border_m, beeper_m, tape_out_m} = '0;
	{rambank_m, vbank_m, rombank_m, lock_m} = '0;
	{hsync_prev, vsync_prev, cpu_prev} = '0;
	int_prev = 1'b1;
	{hfalls, vfalls, int_falls, cpu_rises} = '0;
	{last_hfall, last_vfall, last_int_fall, last_cpu_rise} = '0;
	int_dist = -1;
	screen_px = 0;
	border_px = 0;
	bus_idle();
	xd_drv = 8'h00;
	kd = 5'h1f;
	tape_in = 1'b0;
	for (i = 0; i < 524288; i++) begin
		rnd = $random(seed);
		vram[i] = rnd[7:0];
	end
	@(posedge rst_n);
	for (i = 0; i < N_OPS; i++) begin
		rnd = $random(seed);
		kind = {$random(seed)} % 4;
		if (i == N_OPS / 2)
			io_write(16'h7ffd, rnd[7:0] | 8'h20); // sets lock
		else if (kind == 0)
			io_write(rnd[31:16], i < N_OPS / 2 ? rnd[7:0] & 8'hdf : rnd[7:0]);
		else if (kind == 1)
			fe_read(rnd[31:16]);
		else if (kind == 2)
			mem_read(rnd[31:16]);
		else
			mem_write(rnd[31:16], rnd[7:0]);
		@(posedge clk28);
	end
	io_write(16'h00fe, {rnd[7:3], rnd[2:0] | 3'b001}); // non-black border
	wait (vfalls >= 3 && int_falls >= 3);
	@(negedge clk28);
	if (screen_px == 0 || border_px == 0)
		report_problem("pixel checks did not reach both screen and border");
	print_summary();
	if (errors == 0)
		$display("Regression passed");
	else
		$display("Regression failed");
	$finish;
end

initial begin
	repeat (WATCHDOG_TICKS) @(posedge clk28);
	report_problem($sformatf("run did not finish within %0d clock cycles", WATCHDOG_TICKS));
	print_summary();
	$display("Regression failed");
	$finish;
end

endmodule

`default_nettype wire
